//--- tb/memory_system_golden.txt
# port(i d p) op(r w) addr wdata expected_rdata bus_reads
# p is an instruction read started with the next data line; its bus_reads counts both
i r 00000100 00000000 5a5a0100 1
i r 00000100 00000000 5a5a0100 0
i r 00000140 00000000 5a5a0140 1
d r 00000200 00000000 5a5a0200 1
d w 00000200 0badcafe 00000000 0
d r 00000200 00000000 0badcafe 0
d r 00000240 00000000 5a5a0240 1
i r 00000200 00000000 0badcafe 1
d r 00000200 00000000 0badcafe 1
d w 00000300 12345678 00000000 0
d r 00000300 00000000 12345678 1
d r 80000010 00000000 da5a0010 1
d r 80000010 00000000 da5a0010 1
i r 80000020 00000000 da5a0020 1
i r 80000020 00000000 da5a0020 1
d w 80000030 cafef00d 00000000 0
d r 80000030 00000000 cafef00d 1
d r 00000002 00000000 5a5a0002 1
p r 00000400 00000000 5a5a0400 2
d r 00000480 00000000 5a5a0480 0
p r 00000044 00000000 5a5a0044 2
d r 80000104 00000000 da5a0104 0

//--- list.f
rtl/mem_sys_pkg.sv
rtl/memory_map.sv
rtl/write_through_cache.sv
rtl/ext_mem_arbiter.sv
rtl/memory_system.sv
tb/ext_mem_model.sv
tb/tb_memory_system.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
rm -rf obj_dir &&
verilator --binary --timing --timescale 1ns/10ps --top-module tb_memory_system \
    -f list.f > build.log 2>&1 &&
./obj_dir/Vtb_memory_system > sim.log 2>&1 ||
{ echo "build or simulation failed, see build.log and sim.log"; exit 1; }
grep -qx "Testbench passed" sim.log && echo "simulation passed" ||
{ echo "pass line not found in sim.log"; exit 1; }

//--- tb/tb_memory_system.sv
`timescale 1ns/10ps
`default_nettype none

module tb_memory_system;

    logic        clk = 1'b0;
    logic        rst;
    logic        imem_re;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    logic        dmem_re;
    logic        dmem_wr;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic [31:0] dmem_rdata;
    logic        imem_stall;
    logic        dmem_stall;
    logic        stall;
    logic [31:0] mem_addr;
    logic        en_ext_mem_re;
    logic        en_ext_mem_wr;
    logic [31:0] data_in;
    logic [31:0] data_out;
    logic        mem_ready;

    // golden lines, one entry per access.
    logic [7:0]  g_port  [$];
    logic [7:0]  g_op    [$];
    logic [31:0] g_addr  [$];
    logic [31:0] g_wdata [$];
    logic [31:0] g_expect[$];
    int          g_reads [$];
    int          g_line  [$];

    logic [31:0] read_addrs[$];                         // completed bus reads, in order.
    int          write_count = 0;
    logic [31:0] last_wr_addr;
    logic [31:0] last_wr_data;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    int          k;

    memory_system i_dut (.*);

    ext_mem_model i_mem (
        .clk           (clk),
        .rst           (rst),
        .mem_addr      (mem_addr),
        .en_ext_mem_re (en_ext_mem_re),
        .en_ext_mem_wr (en_ext_mem_wr),
        .data_in       (data_in),
        .data_out      (data_out),
        .mem_ready     (mem_ready)
    );

    always #50 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic stop_with_error(input string msg);
        $display("ERROR: %s", msg);
        $display("Testbench failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic load_golden();
        int          fd;
        int          lineno;
        int          cnt;
        int          r;
        string       line;
        logic [7:0]  port_c;
        logic [7:0]  op_c;
        logic [31:0] a;
        logic [31:0] w;
        logic [31:0] e;
        lineno = 0;
        fd = $fopen("tb/memory_system_golden.txt", "r");
        if (fd == 0) begin
            stop_with_error("cannot open tb/memory_system_golden.txt");
        end
        while ($fgets(line, fd) != 0) begin
            lineno++;
            if (line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;
            end
            cnt = $sscanf(line, "%s %s %h %h %h %d", port_c, op_c, a, w, e, r);
            if (cnt != 6) begin
                stop_with_error($sformatf("golden line %0d cannot be parsed", lineno));
            end
            g_port.push_back(port_c);
            g_op.push_back(op_c);
            g_addr.push_back(a);
            g_wdata.push_back(w);
            g_expect.push_back(e);
            g_reads.push_back(r);
            g_line.push_back(lineno);
        end
        $fclose(fd);
    endtask

    // runs one access, or an instruction and a data access started together.
    task automatic run_access(input int il, input int dl);
        logic        i_done;
        logic        d_done;
        logic        d_first;
        logic        first_cycle;
        logic        busy;
        logic [31:0] i_got;
        logic [31:0] d_got;
        int          base_reads;
        int          base_writes;
        int          n;
        string       tname;
        base_reads  = read_addrs.size();
        base_writes = write_count;
        i_done      = (il < 0);
        d_done      = (dl < 0);
        d_first     = 1'b1;
        first_cycle = 1'b1;
        n           = (il >= 0) ? il : dl;
        tname       = $sformatf("golden line %0d", g_line[n]);
        if (il >= 0) begin
            imem_re   = 1'b1;
            imem_addr = g_addr[il];
        end
        if (dl >= 0) begin
            dmem_re    = (g_op[dl] == "r");
            dmem_wr    = (g_op[dl] == "w");
            dmem_addr  = g_addr[dl];
            dmem_wdata = g_wdata[dl];
        end
        busy = (g_reads[n] != 0) || dmem_wr;           // any bus access holds the pipeline.
        while (!(i_done && d_done)) begin
            @(negedge clk);
            if (first_cycle) begin
                check_value({tname, " stall"}, 32'(busy), 32'(stall));
                first_cycle = 1'b0;
            end
            if (!d_done && !dmem_stall) begin
                d_got  = dmem_rdata;
                d_done = 1'b1;
            end
            if (!i_done && !imem_stall) begin
                i_got   = imem_rdata;
                i_done  = 1'b1;
                d_first = d_done;
            end
            @(posedge clk);
            #1;
            if (i_done) begin
                imem_re   = 1'b0;
                imem_addr = '0;
            end
            if (d_done) begin
                dmem_re    = 1'b0;
                dmem_wr    = 1'b0;
                dmem_addr  = '0;
                dmem_wdata = '0;
            end
        end
        if (il >= 0) begin
            check_value({tname, " imem_rdata"}, g_expect[il], i_got);
        end
        if (dl >= 0 && g_op[dl] == "r") begin
            check_value({tname, " dmem_rdata"}, g_expect[dl], d_got);
        end
        if (dl >= 0 && g_op[dl] == "w") begin
            check_value({tname, " bus writes"}, 32'd1, 32'(write_count - base_writes));
            check_value({tname, " write address"}, g_addr[dl], last_wr_addr);
            check_value({tname, " write data"}, g_wdata[dl], last_wr_data);
        end
        check_value({tname, " bus reads"}, 32'(g_reads[n]),
                    32'(read_addrs.size() - base_reads));
        if (il >= 0 && dl >= 0) begin
            check_value({tname, " first read address"}, g_addr[dl], read_addrs[base_reads]);
            check_value({tname, " data served first"}, 32'd1, 32'(d_first));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus monitor and timeout
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin
        if (en_ext_mem_re && mem_ready) begin
            read_addrs.push_back(mem_addr);
        end
        if (en_ext_mem_wr && mem_ready) begin
            write_count++;
            last_wr_addr = mem_addr;
            last_wr_data = data_in;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            stop_with_error($sformatf("simulation timed out after %0d cycles, arbiter in %s",
                                      cycle_count, i_dut.i_arb.state.name()));
        end
    end

    initial begin
        void'($urandom(32'h075b_b397));
        rst        = 1'b1;
        imem_re    = 1'b0;
        imem_addr  = '0;
        dmem_re    = 1'b0;
        dmem_wr    = 1'b0;
        dmem_addr  = '0;
        dmem_wdata = '0;
        load_golden();
        cycle_limit = 40 * g_addr.size() + 100;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_value("reset en_ext_mem_re", 32'd0, 32'(en_ext_mem_re));
        check_value("reset en_ext_mem_wr", 32'd0, 32'(en_ext_mem_wr));
        check_value("reset imem_stall", 32'd0, 32'(imem_stall));
        check_value("reset dmem_stall", 32'd0, 32'(dmem_stall));
        check_value("reset stall", 32'd0, 32'(stall));
        @(posedge clk);
        #1;
        k = 0;
        while (k < g_addr.size()) begin
            if (g_port[k] == "p") begin
                if (k + 1 >= g_addr.size()) begin
                    stop_with_error("paired golden line has no data line after it");
                end
                run_access(k, k + 1);
                k += 2;
            end else begin
                if (g_port[k] == "i") begin
                    run_access(k, -1);
                end else begin
                    run_access(-1, k);
                end
                k++;
            end
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/ext_mem_model.sv
`timescale 1ns/10ps
`default_nettype none

module ext_mem_model (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [mem_sys_pkg::addr_size-1:0] mem_addr,
    input  logic                              en_ext_mem_re,
    input  logic                              en_ext_mem_wr,
    input  logic [mem_sys_pkg::word_size-1:0] data_in,
    output logic [mem_sys_pkg::word_size-1:0] data_out,
    output logic                              mem_ready
);

    logic [mem_sys_pkg::word_size-1:0] mem [logic [mem_sys_pkg::addr_size-1:0]];
    logic [1:0]                        wait_cnt;
    logic                              issue;

    // words never written hold their own address with a fixed xor.
    function automatic logic [31:0] read_word(input logic [31:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a ^ 32'h5a5a_0000;
    endfunction

    assign issue = (en_ext_mem_re | en_ext_mem_wr) & ~mem_ready & (wait_cnt == 2'd0);

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_ready <= 1'b0;
            data_out  <= '0;
            wait_cnt  <= 2'd0;
        end else begin
            mem_ready <= 1'b0;                          // one cycle pulse.
            if (issue) begin
                mem_ready <= 1'b1;
                if (en_ext_mem_re) begin
                    data_out <= read_word(mem_addr);
                end
                wait_cnt <= 2'($urandom_range(3, 0));   // latency of the next transfer.
            end else if ((en_ext_mem_re | en_ext_mem_wr) & ~mem_ready) begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && issue && en_ext_mem_wr) begin
            mem[mem_addr] = data_in;
        end
    end

endmodule

`default_nettype wire

//--- rtl/memory_system.sv
`timescale 1ns/10ps
`default_nettype none

module memory_system (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              imem_re,
    input  logic [mem_sys_pkg::addr_size-1:0] imem_addr,
    output logic [mem_sys_pkg::word_size-1:0] imem_rdata,
    input  logic                              dmem_re,
    input  logic                              dmem_wr,
    input  logic [mem_sys_pkg::addr_size-1:0] dmem_addr,
    input  logic [mem_sys_pkg::word_size-1:0] dmem_wdata,
    output logic [mem_sys_pkg::word_size-1:0] dmem_rdata,
    output logic                              imem_stall,
    output logic                              dmem_stall,
    output logic                              stall,
    output logic [mem_sys_pkg::addr_size-1:0] mem_addr,
    output logic                              en_ext_mem_re,
    output logic                              en_ext_mem_wr,
    output logic [mem_sys_pkg::word_size-1:0] data_in,
    input  logic [mem_sys_pkg::word_size-1:0] data_out,
    input  logic                              mem_ready
);

    logic                              imem_cacheable;
    logic                              dmem_cacheable;
    logic [mem_sys_pkg::word_size-1:0] icache_rdata;
    logic [mem_sys_pkg::word_size-1:0] dcache_rdata;
    logic                              icache_miss;
    logic                              dcache_miss;
    logic                              icache_ext_re;
    logic                              dcache_ext_re;
    logic                              dcache_ext_wr;
    logic [mem_sys_pkg::addr_size-1:0] icache_ext_addr;
    logic [mem_sys_pkg::addr_size-1:0] dcache_ext_addr;
    logic [mem_sys_pkg::word_size-1:0] dcache_ext_wdata;
    logic                              icache_ack;
    logic                              dcache_ack;

    memory_map i_map (
        .imem_addr      (imem_addr),
        .dmem_addr      (dmem_addr),
        .imem_cacheable (imem_cacheable),
        .dmem_cacheable (dmem_cacheable)
    );

    // instruction side only reads.
    write_through_cache i_icache (
        .clk       (clk),
        .rst       (rst),
        .enable    (imem_cacheable),
        .re        (imem_re),
        .wr        (1'b0),
        .addr      (imem_addr),
        .wdata     ('0),
        .rdata     (icache_rdata),
        .miss      (icache_miss),
        .ext_re    (icache_ext_re),
        .ext_wr    (),
        .ext_addr  (icache_ext_addr),
        .ext_wdata (),
        .ext_rdata (data_out),
        .ext_ack   (icache_ack)
    );

    write_through_cache i_dcache (
        .clk       (clk),
        .rst       (rst),
        .enable    (dmem_cacheable),
        .re        (dmem_re),
        .wr        (dmem_wr),
        .addr      (dmem_addr),
        .wdata     (dmem_wdata),
        .rdata     (dcache_rdata),
        .miss      (dcache_miss),
        .ext_re    (dcache_ext_re),
        .ext_wr    (dcache_ext_wr),
        .ext_addr  (dcache_ext_addr),
        .ext_wdata (dcache_ext_wdata),
        .ext_rdata (data_out),
        .ext_ack   (dcache_ack)
    );

    ext_mem_arbiter i_arb (
        .clk              (clk),
        .rst              (rst),
        .imem_re          (imem_re),
        .imem_cacheable   (imem_cacheable),
        .imem_addr        (imem_addr),
        .dmem_re          (dmem_re),
        .dmem_wr          (dmem_wr),
        .dmem_cacheable   (dmem_cacheable),
        .dmem_addr        (dmem_addr),
        .dmem_wdata       (dmem_wdata),
        .icache_ext_re    (icache_ext_re),
        .icache_miss      (icache_miss),
        .icache_ext_addr  (icache_ext_addr),
        .icache_rdata     (icache_rdata),
        .dcache_ext_re    (dcache_ext_re),
        .dcache_ext_wr    (dcache_ext_wr),
        .dcache_miss      (dcache_miss),
        .dcache_ext_addr  (dcache_ext_addr),
        .dcache_ext_wdata (dcache_ext_wdata),
        .dcache_rdata     (dcache_rdata),
        .icache_ack       (icache_ack),
        .dcache_ack       (dcache_ack),
        .imem_rdata       (imem_rdata),
        .dmem_rdata       (dmem_rdata),
        .imem_stall       (imem_stall),
        .dmem_stall       (dmem_stall),
        .stall            (stall),
        .mem_addr         (mem_addr),
        .data_in          (data_in),
        .en_ext_mem_re    (en_ext_mem_re),
        .en_ext_mem_wr    (en_ext_mem_wr),
        .data_out         (data_out),
        .mem_ready        (mem_ready)
    );

endmodule

`default_nettype wire

//--- rtl/ext_mem_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module ext_mem_arbiter (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              imem_re,
    input  logic                              imem_cacheable,
    input  logic [mem_sys_pkg::addr_size-1:0] imem_addr,
    input  logic                              dmem_re,
    input  logic                              dmem_wr,
    input  logic                              dmem_cacheable,
    input  logic [mem_sys_pkg::addr_size-1:0] dmem_addr,
    input  logic [mem_sys_pkg::word_size-1:0] dmem_wdata,
    input  logic                              icache_ext_re,
    input  logic                              icache_miss,
    input  logic [mem_sys_pkg::addr_size-1:0] icache_ext_addr,
    input  logic [mem_sys_pkg::word_size-1:0] icache_rdata,
    input  logic                              dcache_ext_re,
    input  logic                              dcache_ext_wr,
    input  logic                              dcache_miss,
    input  logic [mem_sys_pkg::addr_size-1:0] dcache_ext_addr,
    input  logic [mem_sys_pkg::word_size-1:0] dcache_ext_wdata,
    input  logic [mem_sys_pkg::word_size-1:0] dcache_rdata,
    output logic                              icache_ack,
    output logic                              dcache_ack,
    output logic [mem_sys_pkg::word_size-1:0] imem_rdata,
    output logic [mem_sys_pkg::word_size-1:0] dmem_rdata,
    output logic                              imem_stall,
    output logic                              dmem_stall,
    output logic                              stall,
    output logic [mem_sys_pkg::addr_size-1:0] mem_addr,
    output logic [mem_sys_pkg::word_size-1:0] data_in,
    output logic                              en_ext_mem_re,
    output logic                              en_ext_mem_wr,
    input  logic [mem_sys_pkg::word_size-1:0] data_out,
    input  logic                              mem_ready
);

    mem_sys_pkg::arb_state_e state;
    mem_sys_pkg::arb_state_e state_next;

    logic i_req;
    logic d_req;
    logic i_own;
    logic d_own;
    logic i_bypass_wait;
    logic d_bypass_wait;

    // a port wants the bus through its cache, or directly when uncached.
    assign i_req = imem_cacheable ? icache_ext_re : imem_re;
    assign d_req = dmem_cacheable ? (dcache_ext_re | dcache_ext_wr) : (dmem_re | dmem_wr);

    assign i_own = (state == mem_sys_pkg::arb_imem);
    assign d_own = (state == mem_sys_pkg::arb_dmem);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ownership FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= mem_sys_pkg::arb_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            mem_sys_pkg::arb_idle: begin
                if (d_req) begin
                    state_next = mem_sys_pkg::arb_dmem;   // data side first.
                end else if (i_req) begin
                    state_next = mem_sys_pkg::arb_imem;
                end
            end
            mem_sys_pkg::arb_dmem,
            mem_sys_pkg::arb_imem: begin
                if (mem_ready) begin
                    state_next = mem_sys_pkg::arb_idle;   // one idle cycle between transfers.
                end
            end
            default: state_next = mem_sys_pkg::arb_idle;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus multiplexer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        mem_addr      = '0;
        data_in       = '0;
        en_ext_mem_re = 1'b0;
        en_ext_mem_wr = 1'b0;
        if (d_own) begin
            if (dmem_cacheable) begin
                mem_addr      = dcache_ext_addr;
                data_in       = dcache_ext_wdata;
                en_ext_mem_re = dcache_ext_re;
                en_ext_mem_wr = dcache_ext_wr;
            end else begin
                mem_addr      = dmem_addr;
                data_in       = dmem_wdata;
                en_ext_mem_re = dmem_re & ~dmem_wr;
                en_ext_mem_wr = dmem_wr;
            end
        end else if (i_own) begin
            mem_addr      = imem_cacheable ? icache_ext_addr : imem_addr;
            en_ext_mem_re = imem_cacheable ? icache_ext_re : imem_re;
        end
    end

    assign icache_ack = i_own & mem_ready;
    assign dcache_ack = d_own & mem_ready;

    // bypass access is outstanding until its own mem_ready.
    assign i_bypass_wait = imem_re & ~(i_own & mem_ready);
    assign d_bypass_wait = (dmem_re | dmem_wr) & ~(d_own & mem_ready);

    assign imem_stall = imem_cacheable ? icache_miss : i_bypass_wait;
    assign dmem_stall = dmem_cacheable ? dcache_miss : d_bypass_wait;
    assign stall      = imem_stall | dmem_stall;

    assign imem_rdata = imem_cacheable ? icache_rdata : data_out;
    assign dmem_rdata = dmem_cacheable ? dcache_rdata : data_out;

endmodule

`default_nettype wire

//--- rtl/write_through_cache.sv
`timescale 1ns/10ps
`default_nettype none

module write_through_cache (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              enable,
    input  logic                              re,
    input  logic                              wr,
    input  logic [mem_sys_pkg::addr_size-1:0] addr,
    input  logic [mem_sys_pkg::word_size-1:0] wdata,
    output logic [mem_sys_pkg::word_size-1:0] rdata,
    output logic                              miss,
    output logic                              ext_re,
    output logic                              ext_wr,
    output logic [mem_sys_pkg::addr_size-1:0] ext_addr,
    output logic [mem_sys_pkg::word_size-1:0] ext_wdata,
    input  logic [mem_sys_pkg::word_size-1:0] ext_rdata,
    input  logic                              ext_ack
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // line storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic [mem_sys_pkg::cache_lines-1:0] valid_q;
    logic [mem_sys_pkg::tag_bits-1:0]    tag_q  [mem_sys_pkg::cache_lines];
    logic [mem_sys_pkg::word_size-1:0]   data_q [mem_sys_pkg::cache_lines];

    mem_sys_pkg::cache_addr_u          a;
    logic [mem_sys_pkg::index_bits-1:0] idx;
    logic                               hit;
    logic                               rd_access;
    logic                               wr_access;
    logic                               fill;
    logic                               wr_update;

    assign a   = addr;
    assign idx = a.f.index;
    assign hit = valid_q[idx] && (tag_q[idx] == a.f.tag);

    // a write takes precedence if both strobes are up.
    assign rd_access = enable & re & ~wr;
    assign wr_access = enable & wr;

    assign fill      = rd_access & ~hit & ext_ack;
    assign wr_update = wr_access & hit & ext_ack;     // write hit refreshes the line.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // external request
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // levels stay up while the port holds its access, until the ack.
    assign ext_re    = rd_access & ~hit;
    assign ext_wr    = wr_access;                     // every write goes out.
    assign ext_addr  = a.raw;
    assign ext_wdata = wdata;

    // the port waits on a read miss or any write, and is released on the ack.
    assign miss = (wr_access | (rd_access & ~hit)) & ~ext_ack;

    // fill data is forwarded in the ack cycle.
    assign rdata = ext_ack ? ext_rdata : data_q[idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (fill) begin
            valid_q[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_q[idx]  <= a.f.tag;
            data_q[idx] <= ext_rdata;
        end else if (wr_update) begin
            data_q[idx] <= wdata;
        end
    end

endmodule

`default_nettype wire

//--- rtl/memory_map.sv
`timescale 1ns/10ps
`default_nettype none

module memory_map (
    input  logic [mem_sys_pkg::addr_size-1:0] imem_addr,
    input  logic [mem_sys_pkg::addr_size-1:0] dmem_addr,
    output logic                              imem_cacheable,
    output logic                              dmem_cacheable
);

    logic imem_in_window;
    logic dmem_in_window;
    logic imem_misaligned;
    logic dmem_misaligned;

    assign imem_in_window = (imem_addr >= mem_sys_pkg::uncached_base) &&
                            (imem_addr <= mem_sys_pkg::uncached_limit);
    assign dmem_in_window = (dmem_addr >= mem_sys_pkg::uncached_base) &&
                            (dmem_addr <= mem_sys_pkg::uncached_limit);

    // a line holds one aligned word, so misaligned accesses go around the cache.
    assign imem_misaligned = |imem_addr[mem_sys_pkg::offset_bits-1:0];
    assign dmem_misaligned = |dmem_addr[mem_sys_pkg::offset_bits-1:0];

    assign imem_cacheable = ~imem_in_window & ~imem_misaligned;
    assign dmem_cacheable = ~dmem_in_window & ~dmem_misaligned;

endmodule

`default_nettype wire

//--- rtl/mem_sys_pkg.sv
`default_nettype none

package mem_sys_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths and cache geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int word_size   = 32;
    localparam int addr_size   = 32;
    localparam int cache_lines = 16;                 // one word per line.
    localparam int index_bits  = 4;
    localparam int tag_bits    = 26;
    localparam int offset_bits = 2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address map
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [addr_size-1:0] uncached_base  = 32'h8000_0000;
    localparam logic [addr_size-1:0] uncached_limit = 32'hFFFF_FFFF;

    // bus ownership of the external memory arbiter.
    typedef enum logic [1:0] {
        arb_idle = 2'b00,
        arb_imem = 2'b01,
        arb_dmem = 2'b10
    } arb_state_e;

    // one address, seen whole or split for the cache lookup.
    typedef union packed {
        logic [addr_size-1:0] raw;
        struct packed {
            logic [tag_bits-1:0]    tag;
            logic [index_bits-1:0]  index;
            logic [offset_bits-1:0] offset;
        } f;
    } cache_addr_u;

endpackage

`default_nettype wire
